// ==== common/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

   localparam int unsigned data_bits = 8;
   localparam int unsigned frame_bits = 11;
   localparam int unsigned words_per_cmd = 2;

   // One frame in line order with the start bit in the MSB.
   typedef struct packed {
      logic                 start;
      logic [data_bits-1:0] data;
      logic                 parity;
      logic                 stop;
   } uart_frame_t;

   typedef struct packed {
      logic [data_bits-1:0] hi;
      logic [data_bits-1:0] lo;
   } uart_cmd_t;

   // Element 1 goes out first.
   typedef uart_frame_t [words_per_cmd-1:0] uart_tx_pair_t;

   typedef struct packed {
      logic [data_bits-1:0] data;
      logic                 parity_err;
      logic                 stop_err;
   } uart_rx_result_t;

   // Parity bit that leaves data plus parity with an odd count of ones.
   function automatic logic odd_parity(input logic [data_bits-1:0] data);
      return ~^data;
   endfunction

endpackage

`default_nettype wire

// ==== uart_tx/uart_frame_builder.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_frame_builder
   import uart_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,
   input  uart_cmd_t     cmd,
   input  logic          cmd_vld,
   input  logic          done,
   output logic          cmd_rdy,
   output logic          load,
   output uart_tx_pair_t pair
);

   logic accept;

   function automatic uart_frame_t make_frame(input logic [data_bits-1:0] data);
      uart_frame_t f;
      f.start  = 1'b0;
      f.data   = data;
      f.parity = odd_parity(data);
      f.stop   = 1'b1;
      return f;
   endfunction

   assign accept = cmd_vld && cmd_rdy;

   // Busy from acceptance until the shifter reports the last bit.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cmd_rdy <= 1'b1;
         load    <= 1'b0;
      end else begin
         load <= accept;
         if (accept)
            cmd_rdy <= 1'b0;
         else if (done)
            cmd_rdy <= 1'b1;
      end
   end

   // High byte goes in element 1.
   always_ff @(posedge clk) begin
      if (accept) begin
         pair[1] <= make_frame(cmd.hi);
         pair[0] <= make_frame(cmd.lo);
      end
   end

   done_only_when_busy: assert property (
      @(posedge clk) disable iff (!rst_n) done |-> !cmd_rdy
   ) else $error("done seen while cmd_rdy is high");

endmodule

`default_nettype wire

// ==== uart_tx/uart_tx_shifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tx_shifter
   import uart_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,
   input  logic          load,
   input  uart_tx_pair_t pair,
   output logic          tx,
   output logic          done
);

   typedef logic [$clog2(words_per_cmd * frame_bits)-1:0] bit_cnt_t;

   logic [words_per_cmd*frame_bits-1:0] sreg;
   bit_cnt_t                            cnt;
   logic                                busy;
   logic                                last_bit;

   assign last_bit = (cnt == bit_cnt_t'(words_per_cmd * frame_bits - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy <= 1'b0;
         cnt  <= '0;
         tx   <= 1'b1;
         done <= 1'b0;
      end else begin
         done <= 1'b0;
         if (load) begin
            busy <= 1'b1;
            cnt  <= '0;
         end else if (busy) begin
            // MSB out at one bit per clock.
            tx <= sreg[$high(sreg)];
            if (last_bit) begin
               busy <= 1'b0;
               done <= 1'b1;
               cnt  <= '0;
            end else begin
               cnt <= cnt + 1'b1;
            end
         end else begin
            tx <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load)
         sreg <= pair;
      else if (busy)
         sreg <= {sreg[$high(sreg)-1:0], 1'b1};
   end

   load_when_idle: assert property (
      @(posedge clk) disable iff (!rst_n) load |-> !busy
   ) else $error("load arrived while shifting");

endmodule

`default_nettype wire

// ==== uart_rx/uart_rx_sampler.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_rx_sampler
   import uart_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        rx,
   output uart_frame_t frame,
   output logic        frame_vld
);

   typedef logic [$clog2(frame_bits)-1:0] bit_cnt_t;

   logic                  rx_meta;
   logic                  rx_sync;
   logic [frame_bits-1:0] sreg;
   bit_cnt_t              cnt;
   logic                  busy;
   logic                  shift_en;

   // Two flops before rx is used anywhere.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

   // A low line while idle is the start bit, and it is kept in the frame.
   assign shift_en = busy || !rx_sync;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy      <= 1'b0;
         cnt       <= '0;
         frame_vld <= 1'b0;
      end else begin
         frame_vld <= 1'b0;
         if (busy) begin
            if (cnt == bit_cnt_t'(frame_bits - 1)) begin
               busy      <= 1'b0;
               cnt       <= '0;
               frame_vld <= 1'b1;
            end else begin
               cnt <= cnt + 1'b1;
            end
         end else if (!rx_sync) begin
            busy <= 1'b1;
            cnt  <= bit_cnt_t'(1);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (shift_en)
         sreg <= {sreg[frame_bits-2:0], rx_sync};
   end

   // Stop bit lands in the LSB on the same edge as frame_vld.
   assign frame = uart_frame_t'(sreg);

   // A pulse is one cycle, and the next one is a whole frame later.
   frame_vld_single: assert property (
      @(posedge clk) disable iff (!rst_n) frame_vld |=> !frame_vld [*(frame_bits - 1)]
   ) else $error("frame_vld repeated within one frame time");

endmodule

`default_nettype wire

// ==== uart_rx/uart_rx_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_rx_checker
   import uart_pkg::*;
(
   input  logic            clk,
   input  logic            rst_n,
   input  uart_frame_t     frame,
   input  logic            frame_vld,
   output uart_rx_result_t read_result,
   output logic            read_rdy
);

   logic parity_bad;
   logic stop_bad;

   // Even count of ones over data plus parity is an error.
   assign parity_bad = (frame.parity != odd_parity(frame.data));
   assign stop_bad   = !frame.stop;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         read_rdy <= 1'b0;
      else
         read_rdy <= frame_vld;
   end

   // Held until the next frame arrives.
   always_ff @(posedge clk) begin
      if (frame_vld) begin
         read_result.data       <= frame.data;
         read_result.parity_err <= parity_bad;
         read_result.stop_err   <= stop_bad;
      end
   end

endmodule

`default_nettype wire

// ==== design/uart_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_top
   import uart_pkg::*;
(
   input  logic            clk,
   input  logic            rst_n,
   input  uart_cmd_t       cmd,
   input  logic            cmd_vld,
   input  logic            rx,
   output logic            cmd_rdy,
   output logic            tx,
   output logic            read_rdy,
   output uart_rx_result_t read_result
);

   uart_tx_pair_t pair;
   logic          load;
   logic          done;
   uart_frame_t   frame;
   logic          frame_vld;

   // Transmit path.
   uart_frame_builder u_frame_builder (
      .clk     (clk),
      .rst_n   (rst_n),
      .cmd     (cmd),
      .cmd_vld (cmd_vld),
      .done    (done),
      .cmd_rdy (cmd_rdy),
      .load    (load),
      .pair    (pair)
   );

   uart_tx_shifter u_tx_shifter (
      .clk   (clk),
      .rst_n (rst_n),
      .load  (load),
      .pair  (pair),
      .tx    (tx),
      .done  (done)
   );

   // Receive path.
   uart_rx_sampler u_rx_sampler (
      .clk       (clk),
      .rst_n     (rst_n),
      .rx        (rx),
      .frame     (frame),
      .frame_vld (frame_vld)
   );

   uart_rx_checker u_rx_checker (
      .clk         (clk),
      .rst_n       (rst_n),
      .frame       (frame),
      .frame_vld   (frame_vld),
      .read_result (read_result),
      .read_rdy    (read_rdy)
   );

endmodule

`default_nettype wire

// ==== verification/uart_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tb
   import uart_pkg::*;
();

   localparam int reset_cycles = 8;
   localparam int n_cmds = 12;
   localparam int n_frames = 40;
   localparam int rx_latency = 4;
   localparam int cmd_cycles = 24;
   localparam int frame_cycles = 15;
   localparam int timeout_limit =
      2 * (n_cmds * cmd_cycles + n_frames * frame_cycles + reset_cycles);
   localparam logic [31:0] seed = 32'hee50c68b;

   logic            clk;
   logic            rst_n;
   uart_cmd_t       cmd;
   logic            cmd_vld;
   logic            rx;
   logic            cmd_rdy;
   logic            tx;
   logic            read_rdy;
   uart_rx_result_t read_result;

   logic            loop_mode;
   logic            rx_drv;
   logic [31:0]     lfsr_state;
   int              cyc = 0;
   int              value_errs = 0;
   int              proto_errs = 0;
   int              rx_seen = 0;

   // Expected receive results and the cycle each one is due.
   uart_rx_result_t exp_res_q[$];
   int              exp_due_q[$];

   assign rx = loop_mode ? tx : rx_drv;

   uart_top uut (
      .clk         (clk),
      .rst_n       (rst_n),
      .cmd         (cmd),
      .cmd_vld     (cmd_vld),
      .rx          (rx),
      .cmd_rdy     (cmd_rdy),
      .tx          (tx),
      .read_rdy    (read_rdy),
      .read_result (read_result)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic lsb;
      lsb = s[0];
      s = s >> 1;
      if (lsb)
         s = s ^ 32'h80200003;
      return s;
   endfunction

   // One LFSR step per bit taken.
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // Builds a frame of start 0, data, odd parity and stop 1 with optional damage.
   function automatic uart_frame_t expected_frame(input logic [data_bits-1:0] data,
                                                  input logic bad_parity,
                                                  input logic bad_stop);
      uart_frame_t f;
      int ones;
      ones = 0;
      for (int i = 0; i < data_bits; i++)
         ones += data[i];
      f.start  = 1'b0;
      f.data   = data;
      f.parity = ((ones % 2) == 0) ^ bad_parity;
      f.stop   = !bad_stop;
      return f;
   endfunction

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
         value_errs++;
      end
   endtask

   task automatic check_result(input string name, input uart_rx_result_t got,
                               input uart_rx_result_t exp);
      if (got !== exp) begin
         $display("FAIL %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
         value_errs++;
      end
   endtask

   task automatic protocol_error(input string msg);
      $display("ERROR: %s at cycle %0d", msg, cyc);
      proto_errs++;
   endtask

   task automatic print_counts();
      $display("Summary: %0d value errors, %0d protocol errors, %0d bytes received",
               value_errs, proto_errs, rx_seen);
   endtask

   // Receive monitor.
   always @(negedge clk) begin
      if (rst_n) begin
         if (read_rdy) begin
            if (exp_res_q.size() == 0) begin
               protocol_error("read_rdy with no frame on the line");
            end else begin
               if (exp_due_q[0] != cyc) begin
                  $display("ERROR: read_rdy at cycle %0d but due at cycle %0d",
                           cyc, exp_due_q[0]);
                  proto_errs++;
               end
               check_result("read_result", read_result, exp_res_q[0]);
               exp_res_q.delete(0);
               exp_due_q.delete(0);
               rx_seen++;
            end
         end else if (exp_due_q.size() > 0 && exp_due_q[0] < cyc) begin
            protocol_error("read_rdy missing");
            exp_res_q.delete(0);
            exp_due_q.delete(0);
         end
      end
   end

   task automatic wait_cmd_rdy();
      int n;
      n = 0;
      while (!cmd_rdy) begin
         if (n == 2 * cmd_cycles) begin
            protocol_error("cmd_rdy stuck low");
            return;
         end
         n++;
         @(negedge clk);
      end
   endtask

   // Sends one command and checks tx bit by bit from edge A+2.
   task automatic send_cmd(input uart_cmd_t c, input logic noisy);
      logic [2*frame_bits-1:0] line;
      logic [31:0]             rnd;
      uart_rx_result_t         r;
      int                      a;
      int                      ones_seen;
      line = {expected_frame(c.hi, 1'b0, 1'b0), expected_frame(c.lo, 1'b0, 1'b0)};
      ones_seen = 0;
      wait_cmd_rdy();
      cmd = c;
      cmd_vld = 1'b1;
      @(negedge clk);
      a = cyc;
      if (loop_mode) begin
         r = '{data: c.hi, parity_err: 1'b0, stop_err: 1'b0};
         exp_res_q.push_back(r);
         exp_due_q.push_back(a + 2 + (frame_bits - 1) + rx_latency);
         r = '{data: c.lo, parity_err: 1'b0, stop_err: 1'b0};
         exp_res_q.push_back(r);
         exp_due_q.push_back(a + 2 + (2 * frame_bits - 1) + rx_latency);
      end
      for (int i = 0; i < 2 + 2 * frame_bits; i++) begin
         if (noisy && rand_bits(1) != 0) begin
            rnd = rand_bits(16);
            cmd = rnd[15:0];
            cmd_vld = 1'b1;
         end else begin
            cmd_vld = 1'b0;
         end
         check_bit("cmd_rdy", cmd_rdy, 1'b0);
         if (i < 2) begin
            check_bit("tx", tx, 1'b1);
         end else begin
            check_bit("tx", tx, line[2*frame_bits-1-(i-2)]);
            if (tx === 1'b1)
               ones_seen++;
         end
         @(negedge clk);
      end
      cmd_vld = 1'b0;
      check_bit("tx", tx, 1'b1);
      check_bit("cmd_rdy", cmd_rdy, 1'b1);
      if (ones_seen == 0 || ones_seen == 2 * frame_bits)
         protocol_error("tx stuck during a command");
   endtask

   // Drives one frame onto rx, one bit per falling edge.
   task automatic drive_frame(input logic [data_bits-1:0] data, input logic bad_parity,
                              input logic bad_stop);
      logic [frame_bits-1:0] bits;
      uart_rx_result_t       r;
      bits = expected_frame(data, bad_parity, bad_stop);
      r = '{data: data, parity_err: bad_parity, stop_err: bad_stop};
      for (int k = 0; k < frame_bits; k++) begin
         rx_drv = bits[frame_bits-1-k];
         if (k == frame_bits - 1) begin
            exp_res_q.push_back(r);
            exp_due_q.push_back(cyc + rx_latency);
         end
         @(negedge clk);
      end
   endtask

   task automatic drain_rx();
      while (exp_res_q.size() > 0)
         @(negedge clk);
      repeat (2) @(negedge clk);
   endtask

   initial begin : stimulus
      uart_cmd_t   c;
      logic [31:0] rnd;
      int          gap;
      logic        bad_p;
      logic        bad_s;
      cmd = '0;
      cmd_vld = 1'b0;
      rx_drv = 1'b1;
      loop_mode = 1'b0;
      rst_n = 1'b0;
      lfsr_state = seed;
      repeat (reset_cycles) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_bit("tx", tx, 1'b1);
      check_bit("cmd_rdy", cmd_rdy, 1'b1);
      check_bit("read_rdy", read_rdy, 1'b0);

      // Loopback with strobes while busy in the second half.
      loop_mode = 1'b1;
      for (int n = 0; n < n_cmds; n++) begin
         rnd = rand_bits(16);
         c = rnd[15:0];
         send_cmd(c, n >= n_cmds / 2);
         gap = int'(rand_bits(2));
         repeat (gap) @(negedge clk);
      end
      drain_rx();

      // Direct frames with some of them damaged.
      loop_mode = 1'b0;
      rx_drv = 1'b1;
      repeat (2) @(negedge clk);
      for (int n = 0; n < n_frames; n++) begin
         rnd = rand_bits(data_bits);
         bad_p = (rand_bits(3) == 0);
         bad_s = (rand_bits(3) == 1);
         drive_frame(rnd[data_bits-1:0], bad_p, bad_s);
         rx_drv = 1'b1;
         if (rand_bits(1) != 0)
            gap = 0;
         else
            gap = int'(rand_bits(2));
         repeat (gap) @(negedge clk);
      end
      drain_rx();

      print_counts();
      if (value_errs == 0 && proto_errs == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

   initial begin : watchdog
      wait (cyc >= timeout_limit);
      $display("ERROR: run did not finish within %0d cycles", timeout_limit);
      print_counts();
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
common/uart_pkg.sv
uart_tx/uart_frame_builder.sv
uart_tx/uart_tx_shifter.sv
uart_rx/uart_rx_sampler.sv
uart_rx/uart_rx_checker.sv
design/uart_top.sv
verification/uart_tb.sv

// ==== Bender.yml ====
package:
  name: uart_link

sources:
  - common/uart_pkg.sv
  - uart_tx/uart_frame_builder.sv
  - uart_tx/uart_tx_shifter.sv
  - uart_rx/uart_rx_sampler.sv
  - uart_rx/uart_rx_checker.sv
  - design/uart_top.sv
  - target: simulation
    files:
      - verification/uart_tb.sv
